// ==== include/bpm_macros.svh ====
`ifndef BPM_MACROS_SVH
`define BPM_MACROS_SVH

// Bus geometry
`define BPM_WORD_WIDTH 32
`define BPM_ADDR_WIDTH 4

// Register map
`define BPM_REG_BUILD_DATE   4'd0
`define BPM_REG_MICROSECONDS 4'd1
`define BPM_REG_SECONDS      4'd2
`define BPM_REG_SOFT_TRIGGER 4'd3
`define BPM_REG_INTERLOCK    4'd4
`define BPM_REG_USER_GPIO    4'd5
`define BPM_REG_SPI_MUX      4'd6

// Firmware identification word
`define BPM_BUILD_DATE 32'h65A1_B2C3

// Timekeeping ratios, shortened for simulation
`define BPM_TICKS_PER_US  5
`define BPM_US_PER_SECOND 20

// Trigger paths
`define BPM_TRIGGER_WIDTH     7
`define BPM_EVR_TRIGGER_WIDTH 8
`define BPM_SOFT_STRETCH      8

`endif

// ==== logic/bootTimer.sv ====
`default_nettype none

`include "bpm_macros.svh"

module bootTimer (
    input  logic              sysClk,
    input  logic              rst,
    output bpmPkg::bootTime_t bootTime
);

    localparam int TickBits = $clog2(`BPM_TICKS_PER_US);
    localparam int UsBits   = $clog2(`BPM_US_PER_SECOND);

    logic [TickBits-1:0] tickCount;
    logic [UsBits-1:0]   usCount;
    logic                usTick;
    logic                secondTick;

    assign usTick     = (tickCount == TickBits'(`BPM_TICKS_PER_US - 1));
    assign secondTick = usTick && (usCount == UsBits'(`BPM_US_PER_SECOND - 1));

    //////////////////////////////////////////////////
    // Prescalers

    always_ff @(posedge sysClk) begin
        if (rst || usTick) begin
            tickCount <= '0;
        end else begin
            tickCount <= tickCount + 1'b1;
        end
    end

    // Counts microseconds within the current second
    always_ff @(posedge sysClk) begin
        if (rst || secondTick) begin
            usCount <= '0;
        end else if (usTick) begin
            usCount <= usCount + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Free-running counts

    always_ff @(posedge sysClk) begin
        if (rst) begin
            bootTime <= '0;
        end else begin
            if (usTick) begin
                bootTime.microseconds <= bootTime.microseconds + 1'b1;
            end
            if (secondTick) begin
                bootTime.seconds <= bootTime.seconds + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/bpmControlTop.sv ====
`default_nettype none

`include "bpm_macros.svh"

module bpmControlTop (
    input  logic                              sysClk,
    input  logic                              rst,
    input  bpmPkg::gpioWrite_t                busWrite,
    input  logic [`BPM_EVR_TRIGGER_WIDTH-1:0] evrTriggerBus,
    input  logic                              swW,
    input  logic                              swE,
    input  logic                              swN,
    input  logic [7:0]                        dipSwitch,
    input  logic [`BPM_ADDR_WIDTH-1:0]        readAddr,
    output logic [`BPM_WORD_WIDTH-1:0]        readData,
    output logic [`BPM_TRIGGER_WIDTH-1:0]     eventTriggerStrobes,
    output logic [7:0]                        gpioLeds,
    output logic [1:0]                        clkSpiMuxSel,
    output logic                              relayControl
);

    bpmPkg::regStrobes_t  regStrobes;
    bpmPkg::gpioWord_u    writeWord;
    bpmPkg::bootTime_t    bootTime;
    bpmPkg::panelStatus_t panelStatus;

    //////////////////////////////////////////////////
    // Decode
    gpioDecode gpioDecode_inst (
        .sysClk(sysClk), .rst(rst), .busWrite(busWrite),
        .regStrobes(regStrobes), .writeWord(writeWord));

    //////////////////////////////////////////////////
    // Execute
    triggerExecute triggerExecute_inst (
        .sysClk(sysClk), .rst(rst), .regStrobes(regStrobes),
        .evrTriggerBus(evrTriggerBus), .eventTriggerStrobes(eventTriggerStrobes));

    bootTimer bootTimer_inst (.sysClk(sysClk), .rst(rst), .bootTime(bootTime));

    panelControl panelControl_inst (
        .sysClk(sysClk), .rst(rst), .regStrobes(regStrobes), .writeWord(writeWord),
        .swW(swW), .swE(swE), .swN(swN), .evrTriggerBus(evrTriggerBus),
        .bootTime(bootTime), .panelStatus(panelStatus), .gpioLeds(gpioLeds),
        .clkSpiMuxSel(clkSpiMuxSel), .relayControl(relayControl));

    //////////////////////////////////////////////////
    // Result
    readbackResult readbackResult_inst (
        .sysClk(sysClk), .rst(rst), .readAddr(readAddr), .bootTime(bootTime),
        .panelStatus(panelStatus), .evrTriggerBus(evrTriggerBus),
        .dipSwitch(dipSwitch), .readData(readData));

endmodule

`default_nettype wire

// ==== logic/bpmPkg.sv ====
`default_nettype none

`include "bpm_macros.svh"

package bpmPkg;

    //////////////////////////////////////////////////
    // Register bus

    // One write from the processor
    typedef struct packed {
        logic                       strobe;
        logic [`BPM_ADDR_WIDTH-1:0] addr;
        logic [`BPM_WORD_WIDTH-1:0] data;
    } gpioWrite_t;

    // One bit per writable register
    typedef struct packed {
        logic softTrigger;
        logic interlock;
        logic spiMux;
    } regStrobes_t;

    //////////////////////////////////////////////////
    // Views of a written word

    typedef struct packed {
        logic [30:0] reserved;
        logic        relayControl;
    } interlockCsr_t;

    typedef struct packed {
        logic [29:0] reserved;
        logic        sel1;
        logic        sel0;
    } spiMuxCsr_t;

    // Interpretation depends on which strobe fires
    typedef union packed {
        logic [`BPM_WORD_WIDTH-1:0] raw;
        interlockCsr_t              interlock;
        spiMuxCsr_t                 spiMux;
    } gpioWord_u;

    //////////////////////////////////////////////////
    // Readback sources

    typedef struct packed {
        logic       resetRecoverySwitch;
        logic       displaySwitch;
        logic       interlockButton;
        logic       relayControl;
        logic [1:0] muxSel;
    } panelStatus_t;

    typedef struct packed {
        logic [31:0] microseconds;
        logic [31:0] seconds;
    } bootTime_t;

endpackage

`default_nettype wire

// ==== logic/gpioDecode.sv ====
`default_nettype none

`include "bpm_macros.svh"

module gpioDecode (
    input  logic                sysClk,
    input  logic                rst,
    input  bpmPkg::gpioWrite_t  busWrite,
    output bpmPkg::regStrobes_t regStrobes,
    output bpmPkg::gpioWord_u   writeWord
);

    bpmPkg::regStrobes_t addrHit;

    //////////////////////////////////////////////////
    // Address compare

    // Read-only and unknown addresses produce no hit
    always_comb begin
        addrHit = '0;
        if (busWrite.strobe) begin
            case (busWrite.addr)
                `BPM_REG_SOFT_TRIGGER: begin
                    addrHit.softTrigger = 1'b1;
                end
                `BPM_REG_INTERLOCK: begin
                    addrHit.interlock = 1'b1;
                end
                `BPM_REG_SPI_MUX: begin
                    addrHit.spiMux = 1'b1;
                end
                default: begin
                    addrHit = '0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Registered strobes and data

    always_ff @(posedge sysClk) begin
        if (rst) begin
            regStrobes <= '0;
        end else begin
            regStrobes <= addrHit;
        end
    end

    // Held until the next accepted write
    always_ff @(posedge sysClk) begin
        if (|addrHit) begin
            writeWord.raw <= busWrite.data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/panelControl.sv ====
`default_nettype none

`include "bpm_macros.svh"

module panelControl (
    input  logic                              sysClk,
    input  logic                              rst,
    input  bpmPkg::regStrobes_t               regStrobes,
    input  bpmPkg::gpioWord_u                 writeWord,
    input  logic                              swW,
    input  logic                              swE,
    input  logic                              swN,
    input  logic [`BPM_EVR_TRIGGER_WIDTH-1:0] evrTriggerBus,
    input  bpmPkg::bootTime_t                 bootTime,
    output bpmPkg::panelStatus_t              panelStatus,
    output logic [7:0]                        gpioLeds,
    output logic [1:0]                        clkSpiMuxSel,
    output logic                              relayControl
);

    // Order is W, E, N from the top bit down
    logic [2:0] swMeta;
    logic [2:0] swSync;

    //////////////////////////////////////////////////
    // Front panel switches

    always_ff @(posedge sysClk) begin
        swMeta <= {swW, swE, swN};
        swSync <= swMeta;
    end

    //////////////////////////////////////////////////
    // Interlock and clock SPI mux registers

    always_ff @(posedge sysClk) begin
        if (rst) begin
            relayControl <= 1'b0;
            clkSpiMuxSel <= 2'b00;
        end else begin
            if (regStrobes.interlock) begin
                relayControl <= writeWord.interlock.relayControl;
            end
            if (regStrobes.spiMux) begin
                clkSpiMuxSel <= {writeWord.spiMux.sel1, writeWord.spiMux.sel0};
            end
        end
    end

    assign panelStatus.resetRecoverySwitch = swSync[2];
    assign panelStatus.displaySwitch       = swSync[1];
    assign panelStatus.interlockButton     = swSync[0];
    assign panelStatus.relayControl        = relayControl;
    assign panelStatus.muxSel              = clkSpiMuxSel;

    // Relay closed lamp lit, relay open lamp dark
    assign gpioLeds = {swSync[0], 1'b0, 1'b1, relayControl,
                       bootTime.seconds[1:0], evrTriggerBus[1:0]};

endmodule

`default_nettype wire

// ==== logic/readbackResult.sv ====
`default_nettype none

`include "bpm_macros.svh"

module readbackResult (
    input  logic                              sysClk,
    input  logic                              rst,
    input  logic [`BPM_ADDR_WIDTH-1:0]        readAddr,
    input  bpmPkg::bootTime_t                 bootTime,
    input  bpmPkg::panelStatus_t              panelStatus,
    input  logic [`BPM_EVR_TRIGGER_WIDTH-1:0] evrTriggerBus,
    input  logic [7:0]                        dipSwitch,
    output logic [`BPM_WORD_WIDTH-1:0]        readData
);

    logic [`BPM_WORD_WIDTH-1:0] selWord;

    //////////////////////////////////////////////////
    // Register views

    always_comb begin
        case (readAddr)
            `BPM_REG_BUILD_DATE: begin
                selWord = `BPM_BUILD_DATE;
            end
            `BPM_REG_MICROSECONDS: begin
                selWord = bootTime.microseconds;
            end
            `BPM_REG_SECONDS: begin
                selWord = bootTime.seconds;
            end
            // Closed reads 1, open reads 0
            `BPM_REG_INTERLOCK: begin
                selWord = {27'b0, panelStatus.relayControl, 1'b0, 1'b0,
                           1'b1, panelStatus.interlockButton};
            end
            `BPM_REG_USER_GPIO: begin
                selWord = {panelStatus.resetRecoverySwitch,
                           panelStatus.displaySwitch,
                           6'b0,
                           evrTriggerBus,
                           8'b0,
                           dipSwitch};
            end
            `BPM_REG_SPI_MUX: begin
                selWord = {30'b0, panelStatus.muxSel};
            end
            // Soft trigger and unknown addresses
            default: begin
                selWord = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Output register

    always_ff @(posedge sysClk) begin
        if (rst) begin
            readData <= '0;
        end else begin
            readData <= selWord;
        end
    end

endmodule

`default_nettype wire

// ==== logic/triggerExecute.sv ====
`default_nettype none

`include "bpm_macros.svh"

module triggerExecute (
    input  logic                              sysClk,
    input  logic                              rst,
    input  bpmPkg::regStrobes_t               regStrobes,
    input  logic [`BPM_EVR_TRIGGER_WIDTH-1:0] evrTriggerBus,
    output logic [`BPM_TRIGGER_WIDTH-1:0]     eventTriggerStrobes
);

    localparam int StretchBits = $clog2(`BPM_SOFT_STRETCH + 1);
    // Lowest event bit that feeds the acquisition triggers
    localparam int EvrLow = `BPM_EVR_TRIGGER_WIDTH - `BPM_TRIGGER_WIDTH + 1;

    logic [StretchBits-1:0]        softCount;
    logic                          softTrigger;
    logic [`BPM_TRIGGER_WIDTH-1:0] trigMeta;
    logic [`BPM_TRIGGER_WIDTH-1:0] trigSync;
    logic [`BPM_TRIGGER_WIDTH-1:0] trigDelay;

    //////////////////////////////////////////////////
    // Software trigger stretcher

    // Another write while counting restarts the stretch
    always_ff @(posedge sysClk) begin
        if (rst) begin
            softCount <= '0;
        end else if (regStrobes.softTrigger) begin
            softCount <= StretchBits'(`BPM_SOFT_STRETCH);
        end else if (softTrigger) begin
            softCount <= softCount - 1'b1;
        end
    end

    assign softTrigger = (softCount != '0);

    //////////////////////////////////////////////////
    // Synchronizer and edge detect

    // Bit 0 carries the software trigger
    always_ff @(posedge sysClk) begin
        trigMeta  <= {evrTriggerBus[`BPM_EVR_TRIGGER_WIDTH-1:EvrLow], softTrigger};
        trigSync  <= trigMeta;
        trigDelay <= trigSync;
    end

    // One cycle per rising edge
    always_ff @(posedge sysClk) begin
        if (rst) begin
            eventTriggerStrobes <= '0;
        end else begin
            eventTriggerStrobes <= trigSync & ~trigDelay;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module bpmControlTb \
    --Mdir obj_dir -o bpmSim
out=$(./obj_dir/bpmSim) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "STATUS: PASS"

// ==== sim/bpmControlTb.sv ====
`default_nettype none

`include "bpm_macros.svh"

module bpmControlTb;

    logic                              sysClk;
    logic                              rst;
    bpmPkg::gpioWrite_t                busWrite;
    logic [`BPM_EVR_TRIGGER_WIDTH-1:0] evrTriggerBus;
    logic                              swW;
    logic                              swE;
    logic                              swN;
    logic [7:0]                        dipSwitch;
    logic [`BPM_ADDR_WIDTH-1:0]        readAddr;
    logic [`BPM_WORD_WIDTH-1:0]        readData;
    logic [`BPM_TRIGGER_WIDTH-1:0]     eventTriggerStrobes;
    logic [7:0]                        gpioLeds;
    logic [1:0]                        clkSpiMuxSel;
    logic                              relayControl;

    int unsigned edgeCount;
    int unsigned cycleCount;
    int unsigned cycleLimit;
    logic        relayModel;

    bpmControlTop bpmControlTop_inst (
        .sysClk(sysClk), .rst(rst), .busWrite(busWrite), .evrTriggerBus(evrTriggerBus),
        .swW(swW), .swE(swE), .swN(swN), .dipSwitch(dipSwitch), .readAddr(readAddr),
        .readData(readData), .eventTriggerStrobes(eventTriggerStrobes),
        .gpioLeds(gpioLeds), .clkSpiMuxSel(clkSpiMuxSel), .relayControl(relayControl));

    //////////////////////////////////////////////////
    // Clock, uptime reference and timeout

    initial sysClk = 1'b0;
    always #10 sysClk = ~sysClk;

    always @(posedge sysClk) begin
        cycleCount = cycleCount + 1;
        if (!rst) begin
            edgeCount = edgeCount + 1;
        end
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("timeout: run exceeded %0d cycles", cycleLimit);
            $display("STATUS: FAIL");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks

    task automatic stopOnError();
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkWord(string name, logic [`BPM_WORD_WIDTH-1:0] got,
                             logic [`BPM_WORD_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkStrobes(logic [`BPM_TRIGGER_WIDTH-1:0] got,
                                logic [`BPM_TRIGGER_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: eventTriggerStrobes got %h expected %h",
                     $time, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkLeds(logic [7:0] got, logic [7:0] exp, logic [7:0] mask);
        if ((got & mask) !== (exp & mask)) begin
            $display("error at %0t: gpioLeds got %h expected %h (mask %h)",
                     $time, got, exp, mask);
            stopOnError();
        end
    endtask

    // Only relayControl and muxSel are compared
    task automatic checkPanel(bpmPkg::panelStatus_t got, bpmPkg::panelStatus_t exp);
        if (got.relayControl !== exp.relayControl || got.muxSel !== exp.muxSel) begin
            $display("error at %0t: relayControl/clkSpiMuxSel got %b/%b expected %b/%b",
                     $time, got.relayControl, got.muxSel, exp.relayControl, exp.muxSel);
            stopOnError();
        end
    endtask

    //////////////////////////////////////////////////
    // Bus operations

    task automatic nextCycle();
        @(posedge sysClk);
        #2;
    endtask

    task automatic busWriteWord(logic [31:0] addr, logic [31:0] data);
        busWrite.strobe = 1'b1;
        busWrite.addr   = addr[`BPM_ADDR_WIDTH-1:0];
        busWrite.data   = data;
        nextCycle();
        busWrite.strobe = 1'b0;
        if (addr[`BPM_ADDR_WIDTH-1:0] == `BPM_REG_INTERLOCK) begin
            relayModel = data[0];
        end
    endtask

    task automatic readExpect(logic [31:0] addr, logic [31:0] exp);
        readAddr = addr[`BPM_ADDR_WIDTH-1:0];
        nextCycle();
        checkWord("readData", readData, exp);
    endtask

    task automatic collectStrobes(int unsigned cycles, logic [31:0] exp);
        logic [`BPM_TRIGGER_WIDTH-1:0] seen;
        seen = '0;
        repeat (cycles) begin
            nextCycle();
            if ((seen & eventTriggerStrobes) != '0) begin
                $display("second strobe on an eventTriggerStrobes bit at %0t", $time);
                stopOnError();
            end
            seen = seen | eventTriggerStrobes;
        end
        checkStrobes(seen, exp[`BPM_TRIGGER_WIDTH-1:0]);
    endtask

    // Synchronizers need three cycles, one more for margin
    task automatic setSwitches(logic [31:0] data);
        swW       = data[10];
        swE       = data[9];
        swN       = data[8];
        dipSwitch = data[7:0];
        repeat (4) nextCycle();
    endtask

    task automatic randomMuxWrite();
        logic [31:0]          word;
        bpmPkg::panelStatus_t exp;
        bpmPkg::panelStatus_t got;
        word = $urandom;
        busWriteWord({28'b0, `BPM_REG_SPI_MUX}, word);
        nextCycle();
        exp = '0;
        exp.relayControl = relayModel;
        exp.muxSel = word[1:0];
        got = '0;
        got.relayControl = relayControl;
        got.muxSel = clkSpiMuxSel;
        checkPanel(got, exp);
        readExpect({28'b0, `BPM_REG_SPI_MUX}, {30'b0, word[1:0]});
    endtask

    task automatic checkPanelPattern(logic [31:0] exp);
        bpmPkg::panelStatus_t want;
        bpmPkg::panelStatus_t got;
        want = '0;
        want.relayControl = exp[4];
        want.muxSel = exp[1:0];
        got = '0;
        got.relayControl = relayControl;
        got.muxSel = clkSpiMuxSel;
        checkPanel(got, want);
    endtask

    // Readback lags the reference count by up to one microsecond
    task automatic checkUptime();
        int unsigned usNow;
        int unsigned usPrev;
        int unsigned secNow;
        logic [31:0] got;
        readAddr = `BPM_REG_MICROSECONDS;
        nextCycle();
        usNow = edgeCount / `BPM_TICKS_PER_US;
        usPrev = (usNow > 0) ? usNow - 1 : 0;
        got = readData;
        if (got !== usPrev) begin
            checkWord("readData microseconds", got, usNow);
        end
        secNow = usNow / `BPM_US_PER_SECOND;
        if ((usNow % `BPM_US_PER_SECOND) != 0 &&
            (usNow % `BPM_US_PER_SECOND) != `BPM_US_PER_SECOND - 1) begin
            checkLeds(gpioLeds, {4'b0, secNow[1:0], 2'b0}, 8'h0c);
        end
        readAddr = `BPM_REG_SECONDS;
        nextCycle();
        usNow = edgeCount / `BPM_TICKS_PER_US;
        usPrev = (usNow > 0) ? usNow - 1 : 0;
        got = readData;
        if (got !== usPrev / `BPM_US_PER_SECOND) begin
            checkWord("readData seconds", got, usNow / `BPM_US_PER_SECOND);
        end
    endtask

    //////////////////////////////////////////////////
    // Pattern file

    task automatic estimateCycles(output int unsigned total);
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        total = 0;
        fd = $fopen("sim/bpm_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open pattern file sim/bpm_patterns.txt");
            stopOnError();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#" &&
                $sscanf(line, "%c %h %h %h", op, addr, data, exp) == 4) begin
                if (op == "N" || op == "C") begin
                    total = total + data;
                end else begin
                    total = total + 8;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic runPatterns();
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        fd = $fopen("sim/bpm_patterns.txt", "r");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#" &&
                $sscanf(line, "%c %h %h %h", op, addr, data, exp) == 4) begin
                case (op)
                    "W": busWriteWord(addr, data);
                    "R": readExpect(addr, exp);
                    "T": begin
                        evrTriggerBus = data[7:0];
                    end
                    "S": setSwitches(data);
                    "N": repeat (data) nextCycle();
                    "C": collectStrobes(data, exp);
                    "M": randomMuxWrite();
                    "P": checkPanelPattern(exp);
                    "L": checkLeds(gpioLeds, exp[7:0], data[7:0]);
                    "U": checkUptime();
                    default: begin
                        $display("unknown operation in pattern line: %s", line);
                        stopOnError();
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        int unsigned total;
        void'($urandom(32'h74778d1d));
        rst           = 1'b1;
        busWrite      = '0;
        evrTriggerBus = '0;
        swW           = 1'b0;
        swE           = 1'b0;
        swN           = 1'b0;
        dipSwitch     = '0;
        readAddr      = '0;
        edgeCount     = 0;
        cycleCount    = 0;
        cycleLimit    = 0;
        relayModel    = 1'b0;
        estimateCycles(total);
        cycleLimit = 2 * (total + 8) + 100;
        repeat (8) @(posedge sysClk);
        #2;
        rst = 1'b0;
        runPatterns();
        if (bpmControlTop_inst.bpmControlAssert_inst.failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/bpmControl_assert.sv ====
`default_nettype none

`include "bpm_macros.svh"

module bpmControlAssert (
    input logic                          sysClk,
    input logic                          rst,
    input bpmPkg::gpioWrite_t            busWrite,
    input logic                          relayControl,
    input logic [`BPM_WORD_WIDTH-1:0]    readData,
    input logic [`BPM_TRIGGER_WIDTH-1:0] eventTriggerStrobes
);

    // Count of failed assertions
    int unsigned failCount = 0;

    // Strobes last one cycle
    strobeSingleCycle: assert property (@(posedge sysClk) disable iff (rst)
        (eventTriggerStrobes & $past(eventTriggerStrobes)) == '0)
        else begin
            $error("trigger strobe held for two cycles");
            failCount++;
        end

    // Relay moves only two cycles after an interlock write
    relayAfterWrite: assert property (@(posedge sysClk) disable iff (rst)
        $changed(relayControl) |->
            $past(busWrite.strobe && (busWrite.addr == `BPM_REG_INTERLOCK), 2))
        else begin
            $error("relayControl changed without an interlock write");
            failCount++;
        end

    readDataReset: assert property (@(posedge sysClk) rst |=> readData == '0)
        else begin
            $error("readData not cleared by reset");
            failCount++;
        end

endmodule

bind bpmControlTop bpmControlAssert bpmControlAssert_inst (
    .sysClk(sysClk), .rst(rst), .busWrite(busWrite), .relayControl(relayControl),
    .readData(readData), .eventTriggerStrobes(eventTriggerStrobes));

`default_nettype wire

// ==== sim/bpm_patterns.txt ====
# op addr data expect, all hex. W write, R read and expect, T set trigger bus,
# S set switches (data 10:8 = swW swE swN, 7:0 = DIP), N wait, C collect strobes, M random mux,
# P panel check (expect 4 = relay, 1:0 = mux), L LEDs under mask (data), U uptime check
R 0 0 65a1b2c3
W 0 ffffffff 0
W 1 00012345 0
W 2 00000777 0
N 0 2 0
R 0 0 65a1b2c3
R 5 0 0
R 3 0 0
R 7 0 0
R f 0 0
W 4 1 0
N 0 2 0
P 0 0 10
R 4 0 12
L 0 70 30
W 6 3 0
N 0 2 0
P 0 0 13
R 6 0 3
R 4 0 12
W 4 0 0
N 0 2 0
P 0 0 03
R 6 0 3
L 0 70 20
M 0 0 0
M 0 0 0
M 0 0 0
M 0 0 0
T 0 4 0
C 0 6 2
T 0 4 0
C 0 8 0
T 0 fc 0
C 0 6 7c
T 0 0 0
C 0 6 0
T 0 fc 0
C 0 6 7e
T 0 0 0
C 0 6 0
W 3 1 0
C 0 14 1
W 3 1 0
N 0 2 0
W 3 1 0
C 0 18 1
U 0 0 0
N 0 37 0
U 0 0 0
N 0 64 0
U 0 0 0
T 0 3 0
C 0 6 0
S 0 5a5 0
R 5 0 800300a5
R 4 0 3
L 0 e3 a3
S 0 200 0
R 5 0 40030000
R 4 0 2
L 0 e3 23

// ==== src.f ====
+incdir+include
logic/bpmPkg.sv
logic/gpioDecode.sv
logic/triggerExecute.sv
logic/bootTimer.sv
logic/panelControl.sv
logic/readbackResult.sv
logic/bpmControlTop.sv
sim/bpmControl_assert.sv
sim/bpmControlTb.sv
